// ==== source/coreSettings.svh ====
// Width and size macros for the integer core. Include this before any port list that uses them.
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// architectural register count, x0 included
`define REG_NUM 32

// register address width, log2 of REG_NUM
`define REG_ADDR_W 5

// integer data width for RV64I
`define XLEN 64

// instruction word width
`define ILEN 32

`endif

// ==== source/corePkg.sv ====
// Shared types for the integer core. Modules import it in their bodies and use scoped names in ports.
`include "coreSettings.svh"

package corePkg;

    // major opcodes that the core accepts
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // register-register view
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } rType_t;

    // register-immediate view
    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } iType_t;

    // one 32-bit word, two decodings
    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instrWord_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_XOR, OP_SRL, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_XORI, OP_ORI, OP_ANDI,
        OP_ILLEGAL
    } aluOp_t;

    // decode to execute
    typedef struct packed {
        aluOp_t                 op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       opA;
        logic [`XLEN-1:0]       opB;
        // low for x0 targets and illegal words
        logic                   writesRd;
    } issue_t;

    // retire port, doubles as the register write request
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
        logic                   illegal;
    } retire_t;

endpackage

// ==== source/intAlu.sv ====
// Combinational 64-bit ALU for the R-type and I-type integer operations.
`timescale 1ns/100ps
`include "coreSettings.svh"

module intAlu (
    input  corePkg::aluOp_t  op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y
);
    import corePkg::*;

    logic [5:0]       shamt;
    logic             lessThan;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;

    // RV64 shifts use six bits of the amount
    assign shamt    = b[5:0];
    assign lessThan = ($signed(a) < $signed(b));
    assign sum      = a + b;
    assign diff     = a - b;

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI: begin
                y = sum;
            end
            OP_SUB: begin
                y = diff;
            end
            OP_SLL: begin
                y = a << shamt;
            end
            OP_SLT, OP_SLTI: begin
                y = {{(`XLEN-1){1'b0}}, lessThan};
            end
            OP_XOR, OP_XORI: begin
                y = a ^ b;
            end
            OP_SRL: begin
                y = a >> shamt;
            end
            OP_OR, OP_ORI: begin
                y = a | b;
            end
            OP_AND, OP_ANDI: begin
                y = a & b;
            end
            // illegal words
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== source/regFile.sv ====
// Integer register file with two operand read ports, one write port and a debug read port.
`timescale 1ns/100ps
`include "coreSettings.svh"

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rdAddrA,
    input  logic [`REG_ADDR_W-1:0] rdAddrB,
    input  logic                   rdEnA,
    input  logic                   rdEnB,
    output logic [`XLEN-1:0]       rdDataA,
    output logic [`XLEN-1:0]       rdDataB,
    input  logic                   wrEn,
    input  corePkg::retire_t       wrReq,
    input  logic [`REG_ADDR_W-1:0] dbgAddr,
    output logic [`XLEN-1:0]       dbgData
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_NUM-1];

    // zero for x0 or a disabled port, write data on a same-cycle match
    function automatic logic [`XLEN-1:0] readReg(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic                   en
    );
        logic [`XLEN-1:0] data;
        data = '0;
        if (en && addr != '0) begin
            if (wrEn && wrReq.rd == addr) begin
                data = wrReq.result;
            end else begin
                data = regs[addr];
            end
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrReq.rd != '0) begin
            regs[wrReq.rd] <= wrReq.result;
        end
    end

    // operand ports
    always_comb begin
        rdDataA = readReg(rdAddrA, rdEnA);
        rdDataB = readReg(rdAddrB, rdEnB);
    end

    // debug port is always enabled
    assign dbgData = readReg(dbgAddr, 1'b1);

    // writesRd from the decoder has to keep x0 out of every write request
    a_noWriteX0: assert property (
        @(posedge clk) disable iff (!arstN)
        wrEn |-> wrReq.rd != '0
    ) else $error("regFile write request targets x0");

endmodule

// ==== source/instrDecoder.sv ====
// Decodes an R-type or I-type word into register reads, an operation and the issued operands.
`timescale 1ns/100ps
`include "coreSettings.svh"

module instrDecoder (
    input  corePkg::instrWord_t    instr,
    output logic [`REG_ADDR_W-1:0] rdAddrA,
    output logic [`REG_ADDR_W-1:0] rdAddrB,
    output logic                   rdEnA,
    output logic                   rdEnB,
    input  logic [`XLEN-1:0]       rdDataA,
    input  logic [`XLEN-1:0]       rdDataB,
    output corePkg::issue_t        issue
);
    import corePkg::*;

    aluOp_t           op;
    logic             isRType;
    logic             legal;
    logic [`XLEN-1:0] immExt;

    always_comb begin
        op      = OP_ILLEGAL;
        isRType = 1'b0;
        case (instr.rType.opcode)
            OPC_OP: begin
                isRType = 1'b1;
                // funct7 then funct3
                case ({instr.rType.funct7, instr.rType.funct3})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_001: op = OP_SLL;
                    10'b0000000_010: op = OP_SLT;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_101: op = OP_SRL;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_111: op = OP_AND;
                    default:         op = OP_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                // immediate shifts and SLTIU are not supported
                case (instr.iType.funct3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    default: op = OP_ILLEGAL;
                endcase
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    assign legal  = (op != OP_ILLEGAL);
    assign immExt = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};

    // rs1 and rd sit at the same bits in both formats
    assign rdAddrA = instr.rType.rs1;
    assign rdAddrB = instr.rType.rs2;
    // only the ports the format reads
    assign rdEnA   = legal;
    assign rdEnB   = legal && isRType;

    always_comb begin
        issue.op       = op;
        issue.rd       = instr.rType.rd;
        issue.opA      = rdDataA;
        issue.opB      = isRType ? rdDataB : immExt;
        issue.writesRd = legal && (issue.rd != '0);
    end

endmodule

// ==== source/execStage.sv ====
// Execute register holding one issued instruction, with the ALU and the retire handshake.
`timescale 1ns/100ps
`include "coreSettings.svh"

module execStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              issueValid,
    input  corePkg::issue_t   issue,
    output logic              issueReady,
    output logic              retireValid,
    output corePkg::retire_t  retire,
    input  logic              retireReady,
    output logic              wrEn
);
    import corePkg::*;

    issue_t           held;
    logic             heldValid;
    logic             loadEn;
    logic             retireFire;
    logic [`XLEN-1:0] aluY;

    assign retireFire = heldValid && retireReady;
    // accept when empty or draining this cycle
    assign issueReady = !heldValid || retireReady;
    assign loadEn     = issueValid && issueReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
        end else if (loadEn) begin
            heldValid <= 1'b1;
        end else if (retireFire) begin
            heldValid <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (loadEn) begin
            held <= issue;
        end
    end

    intAlu uAlu (
        .op (held.op),
        .a  (held.opA),
        .b  (held.opB),
        .y  (aluY)
    );

    assign retireValid = heldValid;

    always_comb begin
        retire.rd      = held.rd;
        retire.result  = aluY;
        retire.illegal = (held.op == OP_ILLEGAL);
    end

    // register write happens on the retire handshake only
    assign wrEn = retireFire && held.writesRd;

    a_retireStable: assert property (
        @(posedge clk) disable iff (!arstN)
        (retireValid && !retireReady) |=> (retireValid && $stable(retire))
    ) else $error("retire changed while stalled");

endmodule

// ==== source/intCore.sv ====
// Top level of the integer execution subsystem: decoder, register file and execute stage.
`timescale 1ns/100ps
`include "coreSettings.svh"

module intCore (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  corePkg::instrWord_t    instr,
    output logic                   instrReady,
    output logic                   retireValid,
    output corePkg::retire_t       retire,
    input  logic                   retireReady,
    input  logic [`REG_ADDR_W-1:0] dbgAddr,
    output logic [`XLEN-1:0]       dbgData
);
    import corePkg::*;

    logic [`REG_ADDR_W-1:0] rdAddrA;
    logic [`REG_ADDR_W-1:0] rdAddrB;
    logic                   rdEnA;
    logic                   rdEnB;
    logic [`XLEN-1:0]       rdDataA;
    logic [`XLEN-1:0]       rdDataB;
    issue_t                 issue;
    logic                   wrEn;

    instrDecoder uDecoder (
        .instr   (instr),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdEnA   (rdEnA),
        .rdEnB   (rdEnB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .issue   (issue)
    );

    // write request is the retire payload itself
    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdEnA   (rdEnA),
        .rdEnB   (rdEnB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrReq   (retire),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    execStage uExec (
        .clk         (clk),
        .arstN       (arstN),
        .issueValid  (instrValid),
        .issue       (issue),
        .issueReady  (instrReady),
        .retireValid (retireValid),
        .retire      (retire),
        .retireReady (retireReady),
        .wrEn        (wrEn)
    );

endmodule

// ==== tests/intCoreRef.svh ====
// Reference model for the integer core testbench: shadow registers, expected retire and xorshift.
`ifndef INT_CORE_REF_SVH
`define INT_CORE_REF_SVH

// architectural state, updated in program order
logic [`XLEN-1:0] shadow [0:`REG_NUM-1] = '{default: '0};

// one xorshift64 step
function automatic logic [63:0] nextRand(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
endfunction

// expected retire of one word, then the write to the shadow registers
function automatic corePkg::retire_t expectedRetire(input logic [31:0] w);
    corePkg::retire_t exp;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm;
    logic             legal;
    a     = shadow[w[19:15]];
    b     = shadow[w[24:20]];
    imm   = {{(`XLEN-12){w[31]}}, w[31:20]};
    legal = 1'b1;
    exp.result = '0;
    if (w[6:0] == 7'b0110011) begin
        // funct7 and funct3 together
        case ({w[31:25], w[14:12]})
            10'b0000000_000: exp.result = a + b;
            10'b0100000_000: exp.result = a - b;
            10'b0000000_001: exp.result = a << b[5:0];
            10'b0000000_010: exp.result = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            10'b0000000_100: exp.result = a ^ b;
            10'b0000000_101: exp.result = a >> b[5:0];
            10'b0000000_110: exp.result = a | b;
            10'b0000000_111: exp.result = a & b;
            default:         legal = 1'b0;
        endcase
    end else if (w[6:0] == 7'b0010011) begin
        case (w[14:12])
            3'b000:  exp.result = a + imm;
            3'b010:  exp.result = ($signed(a) < $signed(imm)) ? 64'd1 : 64'd0;
            3'b100:  exp.result = a ^ imm;
            3'b110:  exp.result = a | imm;
            3'b111:  exp.result = a & imm;
            default: legal = 1'b0;
        endcase
    end else begin
        legal = 1'b0;
    end
    exp.rd      = w[11:7];
    exp.illegal = !legal;
    if (legal && exp.rd != '0) begin
        shadow[exp.rd] = exp.result;
    end
    return exp;
endfunction

`endif

// ==== tests/intCoreTb.sv ====
// Self-checking testbench for intCore; run it through build.sh with Verilator.
`timescale 1ns/100ps
`include "coreSettings.svh"

module intCoreTb;
    import corePkg::*;

    `include "intCoreRef.svh"

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int SWEEP_PER_OP  = 8;
    localparam int CHAIN_COUNT   = 24;
    localparam int STALL_COUNT   = 64;
    localparam int ILLEGAL_COUNT = 8;
    localparam int TOTAL_INSTR   = 31 + 13 * SWEEP_PER_OP + 4 + CHAIN_COUNT + STALL_COUNT
                                   + ILLEGAL_COUNT;
    localparam int LIMIT_CYCLES  = TOTAL_INSTR * 4 + RESET_CYCLES;

    logic                   clk;
    logic                   arstN;
    logic                   instrValid;
    instrWord_t             instr;
    logic                   instrReady;
    logic                   retireValid;
    retire_t                retire;
    logic                   retireReady;
    logic [`REG_ADDR_W-1:0] dbgAddr;
    logic [`XLEN-1:0]       dbgData;

    logic        stallMode;
    logic [63:0] rngState;
    logic [63:0] readyState;
    logic [31:0] issuedWords [0:TOTAL_INSTR-1];
    int          issueCount;
    int          retireCount;
    int          checkErrs;
    int          retireErrs;
    int          testsOk;
    int          testsBad;
    logic        holding;
    retire_t     heldRetire;
    retire_t     exp;

    intCore uut (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .retireValid (retireValid),
        .retire      (retire),
        .retireReady (retireReady),
        .dbgAddr     (dbgAddr),
        .dbgData     (dbgData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // retire back-pressure, random only in stall mode
    initial begin
        retireReady = 1'b1;
        readyState  = nextRand(64'd16);
        forever begin
            @(posedge clk);
            if (stallMode) begin
                readyState = nextRand(readyState);
                retireReady <= readyState[0];
            end else begin
                retireReady <= 1'b1;
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [63:0] drawRand();
        rngState = nextRand(rngState);
        return rngState;
    endfunction

    // k selects ADD..AND (0..7) or ADDI..ANDI (8..12)
    function automatic instrWord_t encodeOp(
        input int                     k,
        input logic [`REG_ADDR_W-1:0] rd,
        input logic [`REG_ADDR_W-1:0] rs1,
        input logic [`REG_ADDR_W-1:0] rs2,
        input logic [11:0]            imm
    );
        instrWord_t w;
        logic [9:0] f73;
        w = '0;
        if (k < 8) begin
            case (k)
                0:       f73 = 10'b0000000_000;
                1:       f73 = 10'b0100000_000;
                2:       f73 = 10'b0000000_001;
                3:       f73 = 10'b0000000_010;
                4:       f73 = 10'b0000000_100;
                5:       f73 = 10'b0000000_101;
                6:       f73 = 10'b0000000_110;
                default: f73 = 10'b0000000_111;
            endcase
            w.rType = '{f73[9:3], rs2, rs1, f73[2:0], rd, 7'b0110011};
        end else begin
            case (k)
                8:       f73 = 10'd0;
                9:       f73 = 10'd2;
                10:      f73 = 10'd4;
                11:      f73 = 10'd6;
                default: f73 = 10'd7;
            endcase
            w.iType = '{imm, rs1, f73[2:0], rd, 7'b0010011};
        end
        return w;
    endfunction

    // called right after a rising edge, returns on the accepting edge
    task automatic sendInstr(input instrWord_t w);
        logic done;
        instrValid <= 1'b1;
        instr      <= w;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = instrReady;
            @(posedge clk);
        end
        issuedWords[issueCount] = w;
        issueCount++;
    endtask

    // opSel below zero picks a random operation
    task automatic sendOps(input int count, input int opSel, input bit chained);
        logic [63:0]            r;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] prevRd;
        int                     k;
        prevRd = 5'd1;
        for (int n = 0; n < count; n++) begin
            r   = drawRand();
            k   = (opSel < 0) ? int'(r[40:37]) % 13 : opSel;
            rd  = r[4:0];
            rs1 = r[9:5];
            if (chained) begin
                rs1 = prevRd;
                if (rd == '0) begin
                    rd = 5'd1;
                end
            end
            sendInstr(encodeOp(k, rd, rs1, r[14:10], r[26:15]));
            prevRd = rd;
        end
    endtask

    task automatic drainRetires();
        instrValid <= 1'b0;
        while (retireCount != issueCount) begin
            @(posedge clk);
        end
    endtask

    task automatic compareRegs();
        for (int r = 0; r < `REG_NUM; r++) begin
            dbgAddr <= `REG_ADDR_W'(r);
            @(negedge clk);
            assert (dbgData == shadow[r]) else begin
                $display("[ERROR] dbgData x%0d got %h expected %h", r, dbgData, shadow[r]);
                checkErrs++;
            end
            @(posedge clk);
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        int errs;
        errs = checkErrs + retireErrs - errsBefore;
        if (errs == 0) begin
            testsOk++;
            $display("test %-14s ok", name);
        end else begin
            testsBad++;
            $display("test %-14s %0d errors", name, errs);
        end
    endtask

    task automatic sendIllegal();
        instrWord_t w;
        logic [63:0] r;
        for (int n = 0; n < ILLEGAL_COUNT; n++) begin
            r = drawRand();
            w = r[31:0];
            w.rType.rd = 5'd3 + 5'(n);
            case (n)
                0: w.rType.opcode = 7'b0000011;
                1: w.rType.opcode = 7'b0110111;
                2: begin
                    // MUL from the M extension
                    w.rType.opcode = OPC_OP;
                    w.rType.funct7 = 7'b0000001;
                end
                3: begin
                    w.rType.opcode = OPC_OP;
                    w.rType.funct7 = 7'b0100000;
                    w.rType.funct3 = 3'b001;
                end
                4: w.iType = '{r[11:0], r[16:12], 3'b001, 5'd9, OPC_OP_IMM};
                5: w.iType = '{r[11:0], r[16:12], 3'b011, 5'd10, OPC_OP_IMM};
                6: w.iType = '{r[11:0], r[16:12], 3'b101, 5'd11, OPC_OP_IMM};
                default: w = '0;
            endcase
            sendInstr(w);
        end
    endtask

    // compare process, sampled mid-cycle where all inputs are stable
    always @(negedge clk) begin
        if (arstN && retireValid) begin
            if (holding) begin
                assert (retire == heldRetire) else begin
                    $display("[ERROR] retire got %h expected %h", retire, heldRetire);
                    retireErrs++;
                end
            end
            if (retireReady) begin
                holding = 1'b0;
                if (retireCount >= issueCount) begin
                    $display("retire handshake with no instruction outstanding");
                    retireErrs++;
                end else begin
                    exp = expectedRetire(issuedWords[retireCount]);
                    retireCount++;
                    assert (retire.rd == exp.rd) else begin
                        $display("[ERROR] retire.rd got %h expected %h", retire.rd, exp.rd);
                        retireErrs++;
                    end
                    assert (retire.result == exp.result) else begin
                        $display("[ERROR] retire.result got %h expected %h",
                                 retire.result, exp.result);
                        retireErrs++;
                    end
                    assert (retire.illegal == exp.illegal) else begin
                        $display("[ERROR] retire.illegal got %h expected %h",
                                 retire.illegal, exp.illegal);
                        retireErrs++;
                    end
                end
            end else begin
                holding    = 1'b1;
                heldRetire = retire;
            end
        end else begin
            holding = 1'b0;
        end
    end

    initial begin
        int errsBefore;
        arstN       = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        dbgAddr     = '0;
        stallMode   = 1'b0;
        rngState    = 64'd16;
        issueCount  = 0;
        retireCount = 0;
        checkErrs   = 0;
        retireErrs  = 0;
        testsOk     = 0;
        testsBad    = 0;
        holding     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);

        errsBefore = 0;
        @(negedge clk);
        assert (!retireValid && instrReady) else begin
            $display("handshake outputs wrong after reset release");
            checkErrs++;
        end
        @(posedge clk);
        compareRegs();
        reportTest("reset", errsBefore);

        // random 12-bit values in every register, then each operation
        errsBefore = checkErrs + retireErrs;
        for (int r = 1; r < `REG_NUM; r++) begin
            rngState = nextRand(rngState);
            sendInstr(encodeOp(8, `REG_ADDR_W'(r), 5'd0, 5'd0, rngState[11:0]));
        end
        for (int k = 0; k < 13; k++) begin
            sendOps(SWEEP_PER_OP, k, 1'b0);
        end
        drainRetires();
        compareRegs();
        reportTest("alu ops", errsBefore);

        errsBefore = checkErrs + retireErrs;
        sendInstr(encodeOp(8, 5'd0, 5'd1, 5'd0, 12'd123));
        sendInstr(encodeOp(0, 5'd0, 5'd1, 5'd2, 12'd0));
        sendInstr(encodeOp(0, 5'd5, 5'd0, 5'd3, 12'd0));
        sendInstr(encodeOp(11, 5'd6, 5'd0, 5'd0, 12'hfff));
        drainRetires();
        compareRegs();
        reportTest("x0", errsBefore);

        errsBefore = checkErrs + retireErrs;
        sendOps(CHAIN_COUNT, -1, 1'b1);
        drainRetires();
        compareRegs();
        reportTest("forwarding", errsBefore);

        errsBefore = checkErrs + retireErrs;
        stallMode <= 1'b1;
        sendOps(STALL_COUNT, -1, 1'b0);
        drainRetires();
        stallMode <= 1'b0;
        compareRegs();
        reportTest("back-pressure", errsBefore);

        errsBefore = checkErrs + retireErrs;
        sendIllegal();
        drainRetires();
        compareRegs();
        reportTest("illegal", errsBefore);

        $display("%0d tests ok, %0d tests with errors, %0d of %0d instructions retired",
                 testsOk, testsBad, retireCount, issueCount);
        if (testsBad == 0 && checkErrs + retireErrs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
+incdir+tests
source/corePkg.sv
source/intAlu.sv
source/regFile.sv
source/instrDecoder.sv
source/execStage.sv
source/intCore.sv
tests/intCoreTb.sv

// ==== build.sh ====
#!/bin/sh
# Compile the integer core testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module intCoreTb -o intCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/intCoreSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
